// ==== common/back_end_params.svh ====
`ifndef BACK_END_PARAMS_SVH
`define BACK_END_PARAMS_SVH

`define BE_XLEN       16 // data path width
`define BE_REG_N      8  // architectural registers
`define BE_REG_IDX    3  // bits of a register index
`define BE_ROB_DEPTH  4  // reorder buffer entries
`define BE_ROB_IDX    2  // bits of a rob index
`define BE_MUL_STEPS  16 // shift-add iterations per multiply

`endif

// ==== common/isa_pkg.sv ====
`default_nettype none

`include "back_end_params.svh"

package isa_pkg;

    // operation codes of the toy machine
    typedef enum logic [2:0] {
        OP_LI  = 3'd0, // rd <- imm
        OP_ADD = 3'd1,
        OP_SUB = 3'd2,
        OP_XOR = 3'd3,
        OP_MUL = 3'd4  // low half of the product only
    } op_t;

    // instruction as delivered by the front end, in program order
    typedef struct packed {
        op_t                    op;
        logic [`BE_REG_IDX-1:0] rd;
        logic [`BE_REG_IDX-1:0] rs1;
        logic [`BE_REG_IDX-1:0] rs2;
        logic [`BE_XLEN-1:0]    imm; // used by LI only
    } instr_t;

endpackage

`default_nettype wire

// ==== common/pipe_pkg.sv ====
`default_nettype none

`include "back_end_params.svh"

package pipe_pkg;

    typedef logic [`BE_ROB_IDX-1:0] rob_idx_t; // tag of an in-flight instruction

    // issue stage to execution unit
    typedef struct packed {
        isa_pkg::op_t        op;
        rob_idx_t            rob_idx; // where the result goes back to
        logic [`BE_XLEN-1:0] opnd_a;  // rs1 value, or the immediate for LI
        logic [`BE_XLEN-1:0] opnd_b;  // rs2 value
    } exec_req_t;

    // result broadcast on the common data bus
    typedef struct packed {
        rob_idx_t            rob_idx;
        logic [`BE_XLEN-1:0] value;
    } cdb_data_t;

    // new rob entry, written at the tail
    typedef struct packed {
        logic [`BE_REG_IDX-1:0] rd;
    } rob_alloc_t;

    // retired result toward the register file
    typedef struct packed {
        logic [`BE_REG_IDX-1:0] rd;
        logic [`BE_XLEN-1:0]    value;
    } commit_t;

endpackage

`default_nettype wire

// ==== exec/mul_counter.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "back_end_params.svh"

module mul_counter (
    input  logic clk_i,
    input  logic reset_i,
    input  logic load_i,  // multiply accepted
    output logic last_o   // current step is the final one
);
    localparam int CNT_W = $clog2(`BE_MUL_STEPS);

    logic [CNT_W-1:0] cnt_q; // steps left after the current one

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            cnt_q <= '0;
        end else if (load_i) begin
            cnt_q <= CNT_W'(`BE_MUL_STEPS - 1);
        end else if (cnt_q != '0) begin
            cnt_q <= cnt_q - 1'b1; // parks at zero
        end
    end

    assign last_o = (cnt_q == '0);

endmodule

`default_nettype wire

// ==== exec/alu_unit.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "back_end_params.svh"

module alu_unit (
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                req_valid_i,
    input  pipe_pkg::exec_req_t req_i,
    output logic                req_ready_o,
    output logic                res_valid_o,
    output pipe_pkg::cdb_data_t res_o,
    input  logic                res_ready_i // bus grant
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic                res_valid_q;
    cdb_data_t           res_q;      // single result slot
    logic                accept;
    logic [`BE_XLEN-1:0] alu_result;

    // free slot, or the held result leaves on this edge
    assign req_ready_o = !res_valid_q || res_ready_i;
    assign accept      = req_valid_i && req_ready_o;

    always_comb begin
        case (req_i.op)
            OP_LI:   alu_result = req_i.opnd_a;                // immediate passes through
            OP_ADD:  alu_result = req_i.opnd_a + req_i.opnd_b; // wraps at 16 bits
            OP_SUB:  alu_result = req_i.opnd_a - req_i.opnd_b;
            OP_XOR:  alu_result = req_i.opnd_a ^ req_i.opnd_b;
            default: alu_result = '0; // MUL is steered elsewhere
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            res_valid_q <= 1'b0;
        end else if (accept) begin
            res_valid_q <= 1'b1;
        end else if (res_ready_i) begin
            res_valid_q <= 1'b0; // drained onto the bus
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            res_q.rob_idx <= req_i.rob_idx;
            res_q.value   <= alu_result;
        end
    end

    assign res_valid_o = res_valid_q;
    assign res_o       = res_q;

endmodule

`default_nettype wire

// ==== exec/mul_unit.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "back_end_params.svh"

module mul_unit (
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                req_valid_i,
    input  pipe_pkg::exec_req_t req_i,
    output logic                req_ready_o,
    output logic                res_valid_o,
    output pipe_pkg::cdb_data_t res_o,
    input  logic                res_ready_i
);
    import pipe_pkg::*;

    typedef enum logic [1:0] {IDLE, BUSY, DONE} mul_state_e;

    mul_state_e          state_q;
    logic [`BE_XLEN-1:0] acc_q;     // partial product, low half only
    logic [`BE_XLEN-1:0] mcand_q;   // multiplicand, shifts left
    logic [`BE_XLEN-1:0] mplier_q;  // multiplier, shifts right
    rob_idx_t            rob_idx_q;
    logic                accept;
    logic                cnt_last;  // final shift-add step

    // a finished product being granted frees the unit in the same cycle
    assign req_ready_o = (state_q == IDLE) || ((state_q == DONE) && res_ready_i);
    assign accept      = req_valid_i && req_ready_o;

    mul_counter u_mul_counter (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .load_i  (accept),
        .last_o  (cnt_last)
    );

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE: if (accept) state_q <= BUSY;
                BUSY: if (cnt_last) state_q <= DONE;
                DONE: begin
                    if (accept) begin
                        state_q <= BUSY; // back to back multiply
                    end else if (res_ready_i) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            acc_q     <= '0;
            mcand_q   <= req_i.opnd_a;
            mplier_q  <= req_i.opnd_b;
            rob_idx_q <= req_i.rob_idx;
        end else if (state_q == BUSY) begin
            acc_q    <= acc_q + (mplier_q[0] ? mcand_q : '0); // add when lsb set
            mcand_q  <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
        end
    end

    assign res_valid_o   = (state_q == DONE); // held until the bus grants it
    assign res_o.rob_idx = rob_idx_q;
    assign res_o.value   = acc_q;

endmodule

`default_nettype wire

// ==== hw/cdb_arbiter.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "back_end_params.svh"

module cdb_arbiter (
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                mul_valid_i,
    input  pipe_pkg::cdb_data_t mul_i,
    output logic                mul_ready_o,
    input  logic                alu_valid_i,
    input  pipe_pkg::cdb_data_t alu_i,
    output logic                alu_ready_o,
    output logic                rob_valid_o,
    output pipe_pkg::cdb_data_t rob_o
);
    import pipe_pkg::*;

    logic      rob_valid_q;
    cdb_data_t rob_q; // bus register, one broadcast per cycle

    // rob always sinks the bus, so the register drains every cycle
    assign mul_ready_o = 1'b1;         // top priority, never blocked
    assign alu_ready_o = !mul_valid_i; // loses whenever the multiplier offers

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rob_valid_q <= 1'b0;
        end else begin
            rob_valid_q <= mul_valid_i || alu_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        rob_q <= mul_valid_i ? mul_i : alu_i; // winner payload
    end

    assign rob_valid_o = rob_valid_q;
    assign rob_o       = rob_q;

endmodule

`default_nettype wire

// ==== rob/rob.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "back_end_params.svh"

module rob (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic                 alloc_valid_i,  // issue accepted an instruction
    input  pipe_pkg::rob_alloc_t alloc_i,
    output logic                 ready_o,        // not full
    output pipe_pkg::rob_idx_t   tail_o,
    input  logic                 cdb_valid_i,
    input  pipe_pkg::cdb_data_t  cdb_i,
    output logic                 commit_valid_o,
    output pipe_pkg::commit_t    commit_o
);
    import pipe_pkg::*;

    localparam int CNT_W = `BE_ROB_IDX + 1; // holds 0..depth

    rob_idx_t   head_q;  // oldest instruction
    rob_idx_t   tail_q;  // next free slot
    logic [CNT_W-1:0] count_q;

    logic [`BE_REG_IDX-1:0]   rd_q    [`BE_ROB_DEPTH];
    logic [`BE_XLEN-1:0]      value_q [`BE_ROB_DEPTH];
    logic [`BE_ROB_DEPTH-1:0] done_q;   // result has come back over the bus

    logic do_commit;

    assign ready_o = (count_q != CNT_W'(`BE_ROB_DEPTH));
    assign tail_o  = tail_q;

    // in-order retire, head must be allocated and finished
    assign do_commit      = (count_q != '0) && done_q[head_q];
    assign commit_valid_o = do_commit;
    assign commit_o.rd    = rd_q[head_q];
    assign commit_o.value = value_q[head_q];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            done_q  <= '0;
        end else begin
            if (do_commit) begin
                done_q[head_q] <= 1'b0;
                head_q         <= head_q + 1'b1; // depth is a power of two, wraps
            end
            if (alloc_valid_i) begin
                done_q[tail_q] <= 1'b0; // waits for its result
                tail_q         <= tail_q + 1'b1;
            end
            if (cdb_valid_i) begin
                done_q[cdb_i.rob_idx] <= 1'b1; // entry is allocated already
            end
            count_q <= count_q + CNT_W'(alloc_valid_i) - CNT_W'(do_commit);
        end
    end

    // entry payload
    always_ff @(posedge clk_i) begin
        if (alloc_valid_i) begin
            rd_q[tail_q] <= alloc_i.rd;
        end
        if (cdb_valid_i) begin
            value_q[cdb_i.rob_idx] <= cdb_i.value;
        end
    end

endmodule

`default_nettype wire

// ==== hw/issue_stage.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "back_end_params.svh"

module issue_stage (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic                 instr_valid_i,
    input  isa_pkg::instr_t      instr_i,
    output logic                 instr_ready_o,
    input  logic                 rob_ready_i,    // rob has a free entry
    input  pipe_pkg::rob_idx_t   rob_tail_i,     // tag for the next instruction
    output logic                 alloc_valid_o,
    output pipe_pkg::rob_alloc_t alloc_o,
    input  logic                 alu_ready_i,
    output logic                 alu_valid_o,
    output pipe_pkg::exec_req_t  alu_req_o,
    input  logic                 mul_ready_i,
    output logic                 mul_valid_o,
    output pipe_pkg::exec_req_t  mul_req_o,
    input  logic                 commit_valid_i,
    input  pipe_pkg::commit_t    commit_i
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic [`BE_XLEN-1:0]  rf_q [`BE_REG_N]; // architectural registers
    logic [`BE_REG_N-1:0] busy_q;           // one writer in flight per register

    logic      is_mul;
    logic      is_li;
    logic      srcs_free;
    logic      can_issue;  // everything but the unit handshake
    logic      unit_ready;
    logic      accept;
    exec_req_t req;

    assign is_mul = (instr_i.op == OP_MUL);
    assign is_li  = (instr_i.op == OP_LI);

    // LI has no source operands
    assign srcs_free  = is_li || (!busy_q[instr_i.rs1] && !busy_q[instr_i.rs2]);
    assign can_issue  = rob_ready_i && srcs_free && !busy_q[instr_i.rd];
    assign unit_ready = is_mul ? mul_ready_i : alu_ready_i;

    assign instr_ready_o = can_issue && unit_ready;
    assign accept        = instr_valid_i && instr_ready_o;

    // steer by opcode, valid never looks at the unit's ready
    assign alu_valid_o = instr_valid_i && can_issue && !is_mul;
    assign mul_valid_o = instr_valid_i && can_issue && is_mul;

    assign alloc_valid_o = accept; // rob entry claimed on the same edge
    assign alloc_o.rd    = instr_i.rd;

    // operand read, no forwarding since sources are never busy here
    always_comb begin
        req.op      = instr_i.op;
        req.rob_idx = rob_tail_i;
        req.opnd_a  = is_li ? instr_i.imm : rf_q[instr_i.rs1];
        req.opnd_b  = rf_q[instr_i.rs2];
    end

    assign alu_req_o = req; // only one of the two valids is ever high
    assign mul_req_o = req;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            busy_q <= '0;
            for (int i = 0; i < `BE_REG_N; i++) begin
                rf_q[i] <= '0; // machine starts with all registers at zero
            end
        end else begin
            if (commit_valid_i) begin
                rf_q[commit_i.rd]   <= commit_i.value;
                busy_q[commit_i.rd] <= 1'b0;
            end
            // rd of a new instruction is free, so it never collides with the commit
            if (accept) begin
                busy_q[instr_i.rd] <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/back_end.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "back_end_params.svh"

module back_end (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              instr_valid_i,
    input  isa_pkg::instr_t   instr_i,
    output logic              instr_ready_o,
    output logic              commit_valid_o, // one retired instruction per high cycle
    output pipe_pkg::commit_t commit_o
);
    import pipe_pkg::*;

    // issue <-> rob
    logic       rob_ready;   // not full
    rob_idx_t   rob_tail;
    logic       alloc_valid;
    rob_alloc_t alloc;

    // issue <-> units
    logic      alu_valid, alu_ready;
    exec_req_t alu_req;
    logic      mul_valid, mul_ready;
    exec_req_t mul_req;

    // units <-> arbiter
    logic      alu_res_valid, alu_res_ready;
    cdb_data_t alu_res;
    logic      mul_res_valid, mul_res_ready;
    cdb_data_t mul_res;

    // arbiter -> rob, never refused
    logic      cdb_valid;
    cdb_data_t cdb;

    issue_stage u_issue_stage (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .instr_valid_i  (instr_valid_i),
        .instr_i        (instr_i),
        .instr_ready_o  (instr_ready_o),
        .rob_ready_i    (rob_ready),
        .rob_tail_i     (rob_tail),
        .alloc_valid_o  (alloc_valid),
        .alloc_o        (alloc),
        .alu_ready_i    (alu_ready),
        .alu_valid_o    (alu_valid),
        .alu_req_o      (alu_req),
        .mul_ready_i    (mul_ready),
        .mul_valid_o    (mul_valid),
        .mul_req_o      (mul_req),
        .commit_valid_i (commit_valid_o), // register file write port
        .commit_i       (commit_o)
    );

    alu_unit u_alu_unit (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .req_valid_i (alu_valid),
        .req_i       (alu_req),
        .req_ready_o (alu_ready),
        .res_valid_o (alu_res_valid),
        .res_o       (alu_res),
        .res_ready_i (alu_res_ready)
    );

    mul_unit u_mul_unit (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .req_valid_i (mul_valid),
        .req_i       (mul_req),
        .req_ready_o (mul_ready),
        .res_valid_o (mul_res_valid),
        .res_o       (mul_res),
        .res_ready_i (mul_res_ready)
    );

    cdb_arbiter u_cdb_arbiter (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .mul_valid_i (mul_res_valid), // higher priority source
        .mul_i       (mul_res),
        .mul_ready_o (mul_res_ready),
        .alu_valid_i (alu_res_valid),
        .alu_i       (alu_res),
        .alu_ready_o (alu_res_ready),
        .rob_valid_o (cdb_valid),
        .rob_o       (cdb)
    );

    rob u_rob (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .alloc_valid_i  (alloc_valid),
        .alloc_i        (alloc),
        .ready_o        (rob_ready),
        .tail_o         (rob_tail),
        .cdb_valid_i    (cdb_valid),
        .cdb_i          (cdb),
        .commit_valid_o (commit_valid_o),
        .commit_o       (commit_o)
    );

endmodule

`default_nettype wire

// ==== tb/back_end_asserts.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "back_end_params.svh"

module back_end_asserts (
    input logic                 clk_i,
    input logic                 reset_i,
    input logic [`BE_ROB_IDX:0] rob_count_i, // entries in use
    input logic                 rob_alloc_i,
    input logic                 rob_ready_i, // rob not full
    input logic [1:0]           mul_state_i,
    input logic                 mul_last_i   // counter on its final step
);
    localparam logic [1:0] MUL_BUSY = 2'd1; // IDLE, BUSY, DONE order in mul_unit

    rob_count_bound: assert property (@(posedge clk_i) disable iff (reset_i)
        rob_count_i <= `BE_ROB_DEPTH)
        else $error("rob count above depth");

    rob_no_alloc_full: assert property (@(posedge clk_i) disable iff (reset_i)
        rob_alloc_i |-> rob_ready_i)
        else $error("rob allocated while full");

    // the multiplier stays in BUSY until the last shift-add step
    mul_busy_hold: assert property (@(posedge clk_i) disable iff (reset_i)
        (mul_state_i == MUL_BUSY && !mul_last_i) |=> (mul_state_i == MUL_BUSY))
        else $error("multiplier left BUSY early");

endmodule

// attached at the top level, watching the rob and the multiplier inside it
bind back_end back_end_asserts u_back_end_asserts (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .rob_count_i (u_rob.count_q),
    .rob_alloc_i (u_rob.alloc_valid_i),
    .rob_ready_i (u_rob.ready_o),
    .mul_state_i (u_mul_unit.state_q),
    .mul_last_i  (u_mul_unit.cnt_last)
);

`default_nettype wire

// ==== tb/tb_back_end.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "back_end_params.svh"

module tb_back_end;
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int TAB_N    = 20;              // stimulus table length
    localparam int WD_LIMIT = TAB_N * 40 + 10; // watchdog budget in cycles, reset included

    logic    clk_i;
    logic    reset_i;
    logic    instr_valid_i;
    instr_t  instr_i;
    logic    instr_ready_o;
    logic    commit_valid_o;
    commit_t commit_o;

    instr_t              tab_instr [TAB_N]; // program, in issue order
    logic                tab_stall [TAB_N]; // 1: ready must be low on the first offer
    int                  tab_fill;
    logic [`BE_XLEN-1:0] model_rf [`BE_REG_N]; // reference register file
    commit_t             exp_q [$];            // expected retire stream
    commit_t             exp_front;

    back_end u_back_end (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .instr_valid_i  (instr_valid_i),
        .instr_i        (instr_i),
        .instr_ready_o  (instr_ready_o),
        .commit_valid_o (commit_valid_o),
        .commit_o       (commit_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i; // 10 ns period
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] act, input logic [31:0] exp);
        if (act !== exp) begin
            fail_run($sformatf("error %s: got 0x%h, expected 0x%h", name, act, exp));
        end
    endtask

    // LI gets a random immediate, other ops carry none
    task automatic add_entry(input op_t op, input logic [2:0] rd, input logic [2:0] rs1,
                             input logic [2:0] rs2, input logic stall);
        instr_t ins;
        ins.op  = op;
        ins.rd  = rd;
        ins.rs1 = rs1;
        ins.rs2 = rs2;
        ins.imm = (op == OP_LI) ? 16'($urandom) : '0;
        tab_instr[tab_fill] = ins;
        tab_stall[tab_fill] = stall;
        tab_fill++;
    endtask

    task automatic fill_table();
        add_entry(OP_LI,  3'd1, 3'd0, 3'd0, 1'b0); // first LI right after reset
        add_entry(OP_LI,  3'd2, 3'd0, 3'd0, 1'b0);
        add_entry(OP_ADD, 3'd3, 3'd1, 3'd2, 1'b1); // chain, waits on r1 and r2
        add_entry(OP_SUB, 3'd4, 3'd3, 3'd1, 1'b1);
        add_entry(OP_XOR, 3'd5, 3'd4, 3'd2, 1'b1);
        add_entry(OP_LI,  3'd6, 3'd0, 3'd0, 1'b0);
        add_entry(OP_LI,  3'd7, 3'd0, 3'd0, 1'b0);
        add_entry(OP_MUL, 3'd1, 3'd6, 3'd7, 1'b1);
        add_entry(OP_ADD, 3'd2, 3'd6, 3'd7, 1'b0); // independent, finishes before the MUL
        add_entry(OP_XOR, 3'd3, 3'd1, 3'd2, 1'b1); // needs the product
        add_entry(OP_SUB, 3'd4, 3'd3, 3'd3, 1'b1);
        add_entry(OP_MUL, 3'd5, 3'd4, 3'd4, 1'b1);
        add_entry(OP_LI,  3'd0, 3'd0, 3'd0, 1'b0); // LIs pile up behind the MUL
        add_entry(OP_LI,  3'd6, 3'd0, 3'd0, 1'b0);
        add_entry(OP_LI,  3'd7, 3'd0, 3'd0, 1'b0);
        add_entry(OP_LI,  3'd1, 3'd0, 3'd0, 1'b1); // rob full here
        add_entry(OP_LI,  3'd2, 3'd0, 3'd0, 1'b0);
        add_entry(OP_ADD, 3'd3, 3'd1, 3'd2, 1'b1);
        add_entry(OP_MUL, 3'd4, 3'd3, 3'd0, 1'b1);
        add_entry(OP_XOR, 3'd5, 3'd4, 3'd6, 1'b1);
    endtask

    // ISA semantics, everything wraps at the data width
    function automatic logic [`BE_XLEN-1:0] model_result(input instr_t ins,
            input logic [`BE_XLEN-1:0] a, input logic [`BE_XLEN-1:0] b);
        logic [2*`BE_XLEN-1:0] prod;
        prod = a * b;
        case (ins.op)
            OP_LI:   return ins.imm;
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_XOR:  return a ^ b;
            OP_MUL:  return prod[`BE_XLEN-1:0]; // low half only
            default: return '0;
        endcase
    endfunction

    task automatic build_expected();
        commit_t c;
        for (int r = 0; r < `BE_REG_N; r++) begin
            model_rf[r] = '0; // machine resets to all zero
        end
        for (int i = 0; i < TAB_N; i++) begin
            c.rd    = tab_instr[i].rd;
            c.value = model_result(tab_instr[i], model_rf[tab_instr[i].rs1],
                                   model_rf[tab_instr[i].rs2]);
            model_rf[c.rd] = c.value;
            exp_q.push_back(c);
        end
    endtask

    // retire monitor, one commit per high cycle
    always @(negedge clk_i) begin
        if (!reset_i && commit_valid_o) begin
            if (exp_q.size() == 0) begin
                fail_run("a commit arrived with no instruction left to retire");
            end else begin
                exp_front = exp_q.pop_front();
                check("commit_o.rd", 32'(commit_o.rd), 32'(exp_front.rd));
                check("commit_o.value", 32'(commit_o.value), 32'(exp_front.value));
            end
        end
    end

    initial begin
        repeat (WD_LIMIT) @(posedge clk_i);
        fail_run("timeout, commits stopped arriving");
    end

    initial begin
        void'($urandom(18));
        reset_i       = 1'b1;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        tab_fill      = 0;
        fill_table();
        build_expected();
        repeat (3) @(posedge clk_i);
        #1 reset_i = 1'b0;
        @(negedge clk_i);
        check("commit_valid_o", 32'(commit_valid_o), 32'h0); // nothing retires out of reset
        @(posedge clk_i);
        #1;
        for (int i = 0; i < TAB_N; i++) begin
            instr_valid_i = 1'b1;
            instr_i       = tab_instr[i];
            @(negedge clk_i);
            check("instr_ready_o", 32'(instr_ready_o), 32'(!tab_stall[i])); // first offer
            while (!instr_ready_o) begin
                @(negedge clk_i);
            end
            @(posedge clk_i); // accepted on this edge
            #1;
        end
        instr_valid_i = 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk_i);
        end
        repeat (8) @(posedge clk_i); // room for a stray extra commit
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+common
common/isa_pkg.sv
common/pipe_pkg.sv
exec/mul_counter.sv
exec/alu_unit.sv
exec/mul_unit.sv
hw/cdb_arbiter.sv
rob/rob.sv
hw/issue_stage.sv
hw/back_end.sv
tb/back_end_asserts.sv
tb/tb_back_end.sv

// ==== Makefile ====
OBJ_DIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_back_end -Mdir $(OBJ_DIR) -o tb_back_end

run: compile
	./$(OBJ_DIR)/tb_back_end | tee sim.log
	@if grep -q "tests failed" sim.log; then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "all tests passed" sim.log; then echo "simulation did not finish"; exit 1; fi
	@echo "simulation PASSED"

clean:
	rm -rf $(OBJ_DIR) sim.log
